// File: source/l1_pkg.sv
// ==============================
// L1 data cache shared definitions
// geometry, MESI state type,
// address field types, line state
// ==============================

package l1_pkg;

    // geometry defaults
    parameter int addr_wid = 32;
    parameter int data_wid = 32;
    parameter int num_sets = 16;
    parameter int num_ways = 2;

    parameter int index_wid = $clog2(num_sets);
    parameter int way_wid   = $clog2(num_ways);
    parameter int tag_wid   = addr_wid - index_wid - 2;

    typedef logic [addr_wid-1:0] addr_t;
    typedef logic [data_wid-1:0] word_t;
    typedef logic [tag_wid-1:0]  tag_t;

    typedef enum logic [1:0] {
        invalid   = 2'b00,
        shared    = 2'b01,
        exclusive = 2'b10,
        modified  = 2'b11
    } mesi_t;

    // one way of one set
    typedef struct packed {
        tag_t  tag;
        mesi_t mesi;
    } line_state_t;

endpackage

// File: source/l1_ifs.sv
// ==============================
// internal interfaces
// l1_lookup_if  tag/state lookup
// l1_data_if    line storage port
// ==============================
`timescale 1ns/1ns

interface l1_lookup_if #(parameter int NUM_WAYS = l1_pkg::num_ways);
    localparam int WW = $clog2(NUM_WAYS);

    l1_pkg::addr_t proc_addr, snoop_addr;
    logic          state_we_proc, tag_we_proc, state_we_snoop;
    logic [WW-1:0] way_proc;
    l1_pkg::mesi_t new_state_proc, new_state_snoop;
    logic          proc_hit, snoop_hit, free;
    logic [WW-1:0] proc_way, snoop_way, victim_way;
    l1_pkg::mesi_t proc_state, snoop_state, victim_state;
    l1_pkg::tag_t  victim_tag;

    modport lookup (input proc_addr, state_we_proc, tag_we_proc, way_proc, new_state_proc,
                    input snoop_addr, state_we_snoop, new_state_snoop,
                    output proc_hit, proc_way, proc_state, free, victim_way, victim_state,
                    output victim_tag, snoop_hit, snoop_way, snoop_state);
    modport proc (output proc_addr, state_we_proc, tag_we_proc, way_proc, new_state_proc,
                  input proc_hit, proc_way, proc_state, free, victim_way, victim_state,
                  input victim_tag, snoop_addr, snoop_state);
    modport snoop (output snoop_addr, state_we_snoop, new_state_snoop,
                   input snoop_hit, snoop_way, snoop_state);
endinterface

interface l1_data_if #(parameter int NUM_SETS = l1_pkg::num_sets,
                       parameter int NUM_WAYS = l1_pkg::num_ways);
    localparam int IW = $clog2(NUM_SETS);
    localparam int WW = $clog2(NUM_WAYS);

    logic          p_rd_en, p_wr_en, s_rd_en, snoop_active;
    logic [IW-1:0] p_index, s_index;
    logic [WW-1:0] p_way, s_way;
    l1_pkg::word_t p_wdata, rdata;

    modport array (input p_rd_en, p_wr_en, p_index, p_way, p_wdata,
                   input s_rd_en, s_index, s_way, snoop_active, output rdata);
    modport proc (output p_rd_en, p_wr_en, p_index, p_way, p_wdata,
                  input rdata, snoop_active, s_rd_en);
    modport snoop (output s_rd_en, s_index, s_way, snoop_active, input rdata);
endinterface

// File: source/l1_tag_lookup.sv
// ==============================
// tag and state arrays
// proc and snoop hit compare
// free way and round-robin victim
// ==============================
`timescale 1ns/1ns

module l1_tag_lookup #(
    parameter int NUM_SETS = l1_pkg::num_sets,
    parameter int NUM_WAYS = l1_pkg::num_ways
) (
    input logic         clk,
    input logic         rst_n,
    l1_lookup_if.lookup lk
);
    localparam int IW = $clog2(NUM_SETS);
    localparam int WW = $clog2(NUM_WAYS);

    l1_pkg::line_state_t st [NUM_SETS][NUM_WAYS];
    logic [WW-1:0]       rr_ptr [NUM_SETS];

    logic [IW-1:0]       p_idx, s_idx;
    l1_pkg::tag_t        p_tag, s_tag;
    logic [NUM_WAYS-1:0] p_match;
    logic [WW-1:0]       free_way;

    assign p_idx = lk.proc_addr[2 +: IW];
    assign s_idx = lk.snoop_addr[2 +: IW];
    assign p_tag = lk.proc_addr[l1_pkg::addr_wid-1 -: l1_pkg::tag_wid];
    assign s_tag = lk.snoop_addr[l1_pkg::addr_wid-1 -: l1_pkg::tag_wid];

    // all ways compared in parallel
    always_comb begin
        lk.proc_hit    = 1'b0;
        lk.proc_way    = '0;
        lk.proc_state  = l1_pkg::invalid;
        lk.snoop_hit   = 1'b0;
        lk.snoop_way   = '0;
        lk.snoop_state = l1_pkg::invalid;
        lk.free        = 1'b0;
        free_way       = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            p_match[w] = st[p_idx][w].mesi != l1_pkg::invalid && st[p_idx][w].tag == p_tag;
            if (p_match[w]) begin
                lk.proc_hit   = 1'b1;
                lk.proc_way   = WW'(w);
                lk.proc_state = st[p_idx][w].mesi;
            end
            if (st[s_idx][w].mesi != l1_pkg::invalid && st[s_idx][w].tag == s_tag) begin
                lk.snoop_hit   = 1'b1;
                lk.snoop_way   = WW'(w);
                lk.snoop_state = st[s_idx][w].mesi;
            end
            if (st[p_idx][w].mesi == l1_pkg::invalid && !lk.free) begin
                lk.free  = 1'b1;
                free_way = WW'(w);
            end
        end
        lk.victim_way   = lk.free ? free_way : rr_ptr[p_idx];
        lk.victim_state = st[p_idx][lk.victim_way].mesi;
        lk.victim_tag   = st[p_idx][lk.victim_way].tag;
    end

    // snoop update comes last so it wins on the same way
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                rr_ptr[s] <= '0;
                for (int w = 0; w < NUM_WAYS; w++)
                    st[s][w].mesi <= l1_pkg::invalid;
            end
        end else begin
            if (lk.state_we_proc)
                st[p_idx][lk.way_proc].mesi <= lk.new_state_proc;
            if (lk.tag_we_proc) begin
                st[p_idx][lk.way_proc].tag <= p_tag;
                rr_ptr[p_idx]              <= lk.way_proc + 1'b1;
            end
            if (lk.state_we_snoop)
                st[s_idx][lk.snoop_way].mesi <= lk.new_state_snoop;
        end
    end

    a_one_hit: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(p_match));

endmodule

// File: source/l1_proc_ctrl.sv
// ==============================
// processor side FSM
// hits, fills, writebacks, invalidates
// ==============================
`timescale 1ns/1ns

module l1_proc_ctrl (
    input  logic          clk,
    input  logic          rst_n,
    input  l1_pkg::addr_t cpu_addr,
    input  logic          cpu_rd,
    input  logic          cpu_wr,
    input  l1_pkg::word_t cpu_wdata,
    output l1_pkg::word_t cpu_rdata,
    output logic          cpu_rd_valid,
    output logic          cpu_wr_done,
    output logic          bus_req,
    input  logic          bus_gnt,
    input  logic          bus_shared,
    output logic          inv_out,
    input  logic          all_inv_done,
    output l1_pkg::addr_t lv2_addr,
    output l1_pkg::word_t lv2_wdata,
    output logic          lv2_rd,
    output logic          lv2_wr,
    input  l1_pkg::word_t lv2_rdata,
    input  logic          lv2_rd_valid,
    input  logic          lv2_wr_done,
    l1_lookup_if.proc     lk,
    l1_data_if.proc       dp
);
    typedef enum logic [2:0] {IDLE, LOOKUP, EVICT, FILL, INVAL, FINISH} state_t;

    state_t          st;
    logic            go, do_hit, evict_now, drop_now, fill_done, inv_done, wb_done, snoop_wb;
    logic            wr_q;
    l1_pkg::addr_t   lv2_addr_q, line_addr, victim_addr;
    logic [$bits(dp.p_way)-1:0] vway;

    assign line_addr   = {cpu_addr[l1_pkg::addr_wid-1:2], 2'b00};
    assign victim_addr = {lk.victim_tag, {(l1_pkg::addr_wid-l1_pkg::tag_wid){1'b0}}}
                       | (l1_pkg::addr_t'(dp.p_index) << 2);

    // ============================
    // decode of this cycle
    // ============================
    always_comb begin
        go        = !dp.snoop_active;
        do_hit    = st == LOOKUP && go && lk.proc_hit && (cpu_rd || lk.proc_state != l1_pkg::shared);
        evict_now = st == LOOKUP && go && bus_gnt && !lk.proc_hit && !lk.free
                    && lk.victim_state == l1_pkg::modified;
        drop_now  = st == LOOKUP && go && bus_gnt && !lk.proc_hit && !lk.free
                    && lk.victim_state != l1_pkg::modified;
        fill_done = st == FILL && lv2_rd_valid;
        inv_done  = st == INVAL && all_inv_done;
        wb_done   = st == EVICT && lv2_wr_done;

        dp.p_index = cpu_addr[2 +: $bits(dp.p_index)];
        dp.p_way   = lk.proc_hit ? lk.proc_way : (st == LOOKUP ? lk.victim_way : vway);
        dp.p_rd_en = (do_hit && cpu_rd) || evict_now;
        dp.p_wr_en = (do_hit && cpu_wr) || inv_done || fill_done;
        dp.p_wdata = fill_done ? lv2_rdata : cpu_wdata;

        lk.proc_addr     = cpu_addr;
        lk.way_proc      = dp.p_way;
        lk.tag_we_proc   = fill_done;
        lk.state_we_proc = dp.p_wr_en || drop_now || wb_done;
        if (fill_done && !cpu_wr)
            lk.new_state_proc = bus_shared ? l1_pkg::shared : l1_pkg::exclusive;
        else if (drop_now || wb_done)
            lk.new_state_proc = l1_pkg::invalid;
        else
            lk.new_state_proc = l1_pkg::modified;
    end

    // snoop writeback borrows the lv2 write path
    assign snoop_wb  = dp.snoop_active && !dp.s_rd_en && lk.snoop_state == l1_pkg::modified;
    assign lv2_wr    = wr_q || snoop_wb;
    assign lv2_addr  = snoop_wb ? {lk.snoop_addr[l1_pkg::addr_wid-1:2], 2'b00} : lv2_addr_q;
    assign lv2_wdata = dp.rdata;

    always_ff @(posedge clk) begin
        cpu_rd_valid <= 1'b0;
        cpu_wr_done  <= 1'b0;
        if (!rst_n) begin
            st      <= IDLE;
            bus_req <= 1'b0;
            inv_out <= 1'b0;
            lv2_rd  <= 1'b0;
            wr_q    <= 1'b0;
        end else begin
            case (st)
                IDLE:
                    if ((cpu_rd || cpu_wr) && !cpu_rd_valid && !cpu_wr_done)
                        st <= LOOKUP;
                LOOKUP:
                    if (do_hit) begin
                        st <= FINISH;
                    end else if (go && !bus_gnt) begin
                        bus_req <= 1'b1;
                    end else if (go && lk.proc_hit) begin
                        inv_out <= 1'b1;
                        st      <= INVAL;
                    end else if (go) begin
                        vway <= lk.victim_way;
                        if (evict_now) begin
                            wr_q       <= 1'b1;
                            lv2_addr_q <= victim_addr;
                            st         <= EVICT;
                        end else begin
                            lv2_rd     <= 1'b1;
                            lv2_addr_q <= line_addr;
                            st         <= FILL;
                        end
                    end
                EVICT:
                    if (lv2_wr_done) begin
                        wr_q       <= 1'b0;
                        lv2_rd     <= 1'b1;
                        lv2_addr_q <= line_addr;
                        st         <= FILL;
                    end
                FILL:
                    // refill done, replay as a hit
                    if (lv2_rd_valid) begin
                        lv2_rd  <= 1'b0;
                        bus_req <= 1'b0;
                        st      <= LOOKUP;
                    end
                INVAL:
                    if (all_inv_done) begin
                        inv_out <= 1'b0;
                        bus_req <= 1'b0;
                        st      <= FINISH;
                    end
                default: begin
                    cpu_rd_valid <= cpu_rd;
                    cpu_wr_done  <= !cpu_rd;
                    cpu_rdata    <= dp.rdata;
                    st           <= IDLE;
                end
            endcase
        end
    end

    a_rd_wr: assert property (@(posedge clk) disable iff (!rst_n) !(cpu_rd && cpu_wr));
    a_lv2:   assert property (@(posedge clk) disable iff (!rst_n) !(lv2_rd && lv2_wr));

endmodule

// File: source/l1_snoop_ctrl.sv
// ==============================
// snoop side controller
// bus read, read-exclusive, invalidate
// ==============================
`timescale 1ns/1ns

module l1_snoop_ctrl (
    input  logic          clk,
    input  logic          rst_n,
    input  l1_pkg::addr_t snoop_addr,
    input  logic          snoop_rd,
    input  logic          snoop_rdx,
    input  logic          snoop_inv,
    output logic          snoop_shared,
    output l1_pkg::word_t snoop_data,
    output logic          snoop_data_valid,
    output logic          snoop_done,
    input  logic          bus_gnt,
    input  logic          lv2_wr_done,
    l1_lookup_if.snoop    lk,
    l1_data_if.snoop      dp
);
    logic reply, start, last;

    // a request is taken only while the bus is idle
    assign start = (snoop_rd || snoop_rdx || snoop_inv) && !bus_gnt && !snoop_done && !reply;
    // modified lines wait for the lv2 writeback
    assign last  = reply && (lk.snoop_state != l1_pkg::modified || lv2_wr_done);

    assign lk.snoop_addr       = snoop_addr;
    assign lk.state_we_snoop   = last;
    assign lk.new_state_snoop  = snoop_rd ? l1_pkg::shared : l1_pkg::invalid;
    assign dp.s_rd_en          = start && lk.snoop_hit;
    assign dp.s_index          = snoop_addr[2 +: $bits(dp.s_index)];
    assign dp.s_way            = lk.snoop_way;
    assign dp.snoop_active     = reply || dp.s_rd_en;

    always_ff @(posedge clk) begin
        snoop_done       <= 1'b0;
        snoop_shared     <= 1'b0;
        snoop_data_valid <= 1'b0;
        if (!rst_n) begin
            reply <= 1'b0;
        end else if (start && !lk.snoop_hit) begin
            snoop_done <= 1'b1;
        end else if (dp.s_rd_en) begin
            reply <= 1'b1;
        end else if (last) begin
            reply            <= 1'b0;
            snoop_done       <= 1'b1;
            snoop_shared     <= snoop_rd;
            snoop_data_valid <= snoop_rd;
            snoop_data       <= dp.rdata;
        end
    end

    a_one_snoop: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({snoop_rd, snoop_rdx, snoop_inv}));

endmodule

// File: source/l1_data_array.sv
// ==============================
// line storage
// one registered read, one write
// ==============================
`timescale 1ns/1ns

module l1_data_array #(
    parameter int NUM_SETS = l1_pkg::num_sets,
    parameter int NUM_WAYS = l1_pkg::num_ways
) (
    input logic        clk,
    l1_data_if.array   dp
);
    localparam int IW = $clog2(NUM_SETS);
    localparam int WW = $clog2(NUM_WAYS);

    l1_pkg::word_t mem [NUM_SETS*NUM_WAYS];

    logic [IW-1:0] rd_index;
    logic [WW-1:0] rd_way;
    logic          rd_en;

    // snoop owns the read port while active
    assign rd_en    = dp.snoop_active ? dp.s_rd_en : dp.p_rd_en;
    assign rd_index = dp.snoop_active ? dp.s_index : dp.p_index;
    assign rd_way   = dp.snoop_active ? dp.s_way : dp.p_way;

    always_ff @(posedge clk) begin
        if (dp.p_wr_en)
            mem[{dp.p_index, dp.p_way}] <= dp.p_wdata;
        if (rd_en)
            dp.rdata <= mem[{rd_index, rd_way}];
    end

endmodule

// File: source/l1_dcache.sv
// ==============================
// L1 data cache top level
// lookup, controllers and data array
// ==============================
`timescale 1ns/1ns

module l1_dcache #(
    parameter int NUM_SETS = l1_pkg::num_sets,
    parameter int NUM_WAYS = l1_pkg::num_ways
) (
    input  logic          clk,
    input  logic          rst_n,
    input  l1_pkg::addr_t cpu_addr,
    input  l1_pkg::word_t cpu_wdata,
    input  logic          cpu_rd,
    input  logic          cpu_wr,
    output l1_pkg::word_t cpu_rdata,
    output logic          cpu_rd_valid,
    output logic          cpu_wr_done,
    output logic          bus_req,
    input  logic          bus_gnt,
    input  logic          bus_shared,
    output l1_pkg::addr_t lv2_addr,
    output l1_pkg::word_t lv2_wdata,
    output logic          lv2_rd,
    output logic          lv2_wr,
    input  l1_pkg::word_t lv2_rdata,
    input  logic          lv2_rd_valid,
    input  logic          lv2_wr_done,
    output logic          inv_out,
    input  logic          all_inv_done,
    input  l1_pkg::addr_t snoop_addr,
    input  logic          snoop_rd,
    input  logic          snoop_rdx,
    input  logic          snoop_inv,
    output logic          snoop_shared,
    output l1_pkg::word_t snoop_data,
    output logic          snoop_data_valid,
    output logic          snoop_done
);
    l1_lookup_if #(.NUM_WAYS(NUM_WAYS)) lk ();
    l1_data_if #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) dp ();

    l1_tag_lookup #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) tag0 (
        .clk(clk), .rst_n(rst_n), .lk(lk.lookup));

    l1_proc_ctrl proc0 (
        .clk(clk), .rst_n(rst_n), .cpu_addr(cpu_addr), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr),
        .cpu_wdata(cpu_wdata), .cpu_rdata(cpu_rdata), .cpu_rd_valid(cpu_rd_valid),
        .cpu_wr_done(cpu_wr_done), .bus_req(bus_req), .bus_gnt(bus_gnt),
        .bus_shared(bus_shared), .inv_out(inv_out), .all_inv_done(all_inv_done),
        .lv2_addr(lv2_addr), .lv2_wdata(lv2_wdata), .lv2_rd(lv2_rd), .lv2_wr(lv2_wr),
        .lv2_rdata(lv2_rdata), .lv2_rd_valid(lv2_rd_valid), .lv2_wr_done(lv2_wr_done),
        .lk(lk.proc), .dp(dp.proc));

    l1_snoop_ctrl snoop0 (
        .clk(clk), .rst_n(rst_n), .snoop_addr(snoop_addr), .snoop_rd(snoop_rd),
        .snoop_rdx(snoop_rdx), .snoop_inv(snoop_inv), .snoop_shared(snoop_shared),
        .snoop_data(snoop_data), .snoop_data_valid(snoop_data_valid),
        .snoop_done(snoop_done), .bus_gnt(bus_gnt), .lv2_wr_done(lv2_wr_done),
        .lk(lk.snoop), .dp(dp.snoop));

    l1_data_array #(.NUM_SETS(NUM_SETS), .NUM_WAYS(NUM_WAYS)) data0 (
        .clk(clk), .dp(dp.array));

endmodule

// File: tests/tb_l1_dcache.sv
// ==============================
// testbench for the L1 data cache
// clock and reset, level-2 memory and bus models,
// pattern player, compare tasks, watchdog
// ==============================
`timescale 1ns/1ns

module tb_l1_dcache;

    localparam int MAX_OPS = 64;
    localparam int PERIOD  = 40;

    logic          clk, rst_n;
    l1_pkg::addr_t cpu_addr, lv2_addr, snoop_addr;
    l1_pkg::word_t cpu_wdata, cpu_rdata, lv2_wdata, lv2_rdata, snoop_data;
    logic          cpu_rd, cpu_wr, cpu_rd_valid, cpu_wr_done, bus_req, bus_gnt, bus_shared;
    logic          lv2_rd, lv2_wr, lv2_rd_valid, lv2_wr_done, inv_out, all_inv_done;
    logic          snoop_rd, snoop_rdx, snoop_inv, snoop_shared, snoop_data_valid, snoop_done;

    logic [31:0]   pat [MAX_OPS*4];
    int            num_ops = 0;
    int            rd_cnt = 0;
    int            wr_cnt = 0;
    int            inv_cnt = 0;
    int            req_cnt = 0;
    int            data_errs = 0;
    int            addr_errs = 0;
    int            flag_errs = 0;
    int            timeouts = 0;
    l1_pkg::addr_t last_rd_addr;
    l1_pkg::word_t l2_mem [l1_pkg::addr_t];
    l1_pkg::addr_t wb_addr_log [$];
    l1_pkg::word_t wb_data_log [$];

    l1_dcache #(.NUM_SETS(16), .NUM_WAYS(2)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // ==============================
    // level-2 memory and other caches
    // ==============================

    // unwritten words read back as the inverted address
    function automatic l1_pkg::word_t l2_read(l1_pkg::addr_t a);
        if (l2_mem.exists(a))
            return l2_mem[a];
        return ~a;
    endfunction

    initial begin
        int            wait_n;
        logic          is_wr;
        l1_pkg::addr_t a;
        l1_pkg::word_t d;
        void'($urandom(40223));
        lv2_rd_valid = 1'b0;
        lv2_wr_done  = 1'b0;
        lv2_rdata    = '0;
        forever begin
            @(posedge clk);
            #5;
            if (rst_n && (lv2_rd || lv2_wr)) begin
                is_wr  = lv2_wr;
                a      = lv2_addr;
                d      = lv2_wdata;
                wait_n = $urandom_range(4, 1);
                if (is_wr) begin
                    wr_cnt++;
                end else begin
                    rd_cnt++;
                    last_rd_addr = a;
                end
                repeat (wait_n - 1) begin
                    @(posedge clk);
                    #5;
                end
                if (is_wr) begin
                    l2_mem[a] = d;
                    wb_addr_log.push_back(a);
                    wb_data_log.push_back(d);
                    lv2_wr_done = 1'b1;
                end else begin
                    lv2_rdata    = l2_read(a);
                    lv2_rd_valid = 1'b1;
                end
                @(posedge clk);
                #5;
                lv2_rd_valid = 1'b0;
                lv2_wr_done  = 1'b0;
            end
        end
    end

    // grant one cycle after request and acks two cycles after inv_out
    initial begin
        logic req_d, inv_d1, inv_d2;
        bus_gnt      = 1'b0;
        all_inv_done = 1'b0;
        req_d        = 1'b0;
        inv_d1       = 1'b0;
        inv_d2       = 1'b0;
        forever begin
            @(posedge clk);
            #5;
            if (rst_n) begin
                if (inv_out && !inv_d1)
                    inv_cnt++;
                if (bus_req && !req_d)
                    req_cnt++;
                bus_gnt      = req_d;
                req_d        = bus_req;
                inv_d2       = inv_d1;
                inv_d1       = inv_out;
                all_inv_done = inv_d1 && inv_d2;
            end
        end
    end

    // ==============================
    // compare tasks
    // ==============================
    task automatic check_data(string name, l1_pkg::word_t exp, l1_pkg::word_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            data_errs++;
        end
    endtask

    task automatic check_addr(string name, l1_pkg::addr_t exp, l1_pkg::addr_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            addr_errs++;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            flag_errs++;
        end
    endtask

    // ==============================
    // pattern player
    // ==============================
    function automatic string kind_label(logic [3:0] kind);
        case (kind)
            4'd1:    return "read";
            4'd2:    return "write";
            4'd3:    return "wb_check";
            4'd4:    return "snoop_rd";
            4'd5:    return "snoop_rdx";
            default: return "snoop_inv";
        endcase
    endfunction

    function automatic logic done_seen(logic [3:0] kind);
        case (kind)
            4'd1:    return cpu_rd_valid;
            4'd2:    return cpu_wr_done;
            default: return snoop_done;
        endcase
    endfunction

    function automatic int count_ops();
        int n;
        n = 0;
        while (n < MAX_OPS && pat[4*n] != 0)
            n++;
        return n;
    endfunction

    // pulses sampled mid-cycle
    task automatic wait_done(logic [3:0] kind, string name);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #5;
            n++;
        end while (!done_seen(kind) && n < 40);
        if (!done_seen(kind)) begin
            $display("%s: no done pulse within 40 cycles", name);
            timeouts++;
        end
    endtask

    task automatic run_op(int line);
        logic [31:0] op, addr, arg, exp;
        logic [3:0]  kind;
        string       name;
        int          rd0, wr0, inv0, req0;
        op   = pat[4*line];
        addr = pat[4*line+1];
        arg  = pat[4*line+2];
        exp  = pat[4*line+3];
        kind = op[3:0];
        name = $sformatf("t%0d_%s_%0d", op[19:16], kind_label(kind), line);
        rd0  = rd_cnt;
        wr0  = wr_cnt;
        inv0 = inv_cnt;
        req0 = req_cnt;
        case (kind)
            4'd1: begin
                cpu_addr   = addr;
                bus_shared = arg[0];
                cpu_rd     = 1'b1;
                wait_done(kind, name);
                cpu_rd = 1'b0;
                check_data(name, exp, cpu_rdata);
            end
            4'd2: begin
                cpu_addr   = addr;
                cpu_wdata  = arg;
                bus_shared = 1'b0;
                cpu_wr     = 1'b1;
                wait_done(kind, name);
                cpu_wr = 1'b0;
            end
            4'd3: begin
                if (wb_addr_log.size() == 0) begin
                    $display("%s: no level-2 write was seen", name);
                    flag_errs++;
                end else begin
                    check_addr(name, addr, wb_addr_log[$]);
                    check_data(name, exp, wb_data_log[$]);
                end
            end
            default: begin
                snoop_addr = addr;
                snoop_rd   = kind == 4'd4;
                snoop_rdx  = kind == 4'd5;
                snoop_inv  = kind == 4'd6;
                wait_done(kind, name);
                snoop_rd  = 1'b0;
                snoop_rdx = 1'b0;
                snoop_inv = 1'b0;
                check_flag({name, "_shared"}, arg[0], snoop_shared);
                check_flag({name, "_data_valid"}, arg[0], snoop_data_valid);
                if (arg[0])
                    check_data(name, exp, snoop_data);
            end
        endcase
        // misses and shared write hits request the bus
        if (kind != 4'd3) begin
            check_flag({name, "_bus_req"}, op[12] || op[4], req_cnt != req0);
            check_flag({name, "_lv2_rd"}, op[12], rd_cnt != rd0);
            check_flag({name, "_lv2_wr"}, op[8], wr_cnt != wr0);
            check_flag({name, "_inv_out"}, op[4], inv_cnt != inv0);
        end
        if (op[12])
            check_addr(name, addr & ~32'h3, last_rd_addr);
    endtask

    initial begin
        rst_n      = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        cpu_rd     = 1'b0;
        cpu_wr     = 1'b0;
        bus_shared = 1'b0;
        snoop_addr = '0;
        snoop_rd   = 1'b0;
        snoop_rdx  = 1'b0;
        snoop_inv  = 1'b0;
        for (int i = 0; i < MAX_OPS*4; i++)
            pat[i] = '0;
        $readmemh("tests/l1_patterns.mem", pat);
        num_ops = count_ops();
        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;
        for (int i = 0; i < num_ops; i++)
            run_op(i);
        $display("errors: data %0d, addr %0d, flag %0d, timeout %0d",
                 data_errs, addr_errs, flag_errs, timeouts);
        if (data_errs + addr_errs + flag_errs + timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog allows 60 cycles per pattern line
    initial begin
        wait (num_ops > 0);
        #(num_ops * 60 * PERIOD);
        $display("watchdog: pattern run did not end within %0d cycles", num_ops * 60);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: tests/l1_patterns.mem
// op digits: test, lv2_rd seen, lv2_wr seen, inv_out seen, kind (1 rd 2 wr 3 wb 4 srd 5 srdx 6 sinv)
// then address (wb check: writeback address), wdata or shared flag, expected data
11001 00001004 00000000 ffffeffb
10001 00001004 00000000 ffffeffb
21001 00002008 00000000 ffffdff7
20002 00002008 11112222 00000000
20001 00002008 00000000 11112222
31001 0000300c 00000001 ffffcff3
30012 0000300c 33334444 00000000
30001 0000300c 00000000 33334444
41002 00004010 55556666 00000000
41001 00005010 00000000 ffffafef
41101 00006010 00000000 ffff9fef
40003 00004010 00000000 55556666
41001 00004010 00000000 55556666
51002 00007014 77778888 00000000
50104 00007014 00000001 77778888
50003 00007014 00000000 77778888
50012 00007014 9999aaaa 00000000
61001 00008018 00000000 ffff7fe7
60005 00008018 00000000 00000000
61001 00008018 00000000 ffff7fe7
60006 00008018 00000000 00000000
61001 00008018 00000000 ffff7fe7
60006 0000a018 00000000 00000000
60005 0000b018 00000000 00000000

// File: l1_dcache.f
source/l1_pkg.sv
source/l1_ifs.sv
source/l1_tag_lookup.sv
source/l1_proc_ctrl.sv
source/l1_snoop_ctrl.sv
source/l1_data_array.sv
source/l1_dcache.sv
tests/tb_l1_dcache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_l1_dcache
RTL_TOP   ?= l1_dcache
FILELIST  ?= l1_dcache.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); test $$rc -eq 0
	! grep -q "TB FAILED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
